//--- common/itemMap_settings.svh
// item map settings: slot count, field widths, grid span and generator constants
`ifndef ITEM_MAP_SETTINGS_SVH
`define ITEM_MAP_SETTINGS_SVH

// item storage
`define ITEM_SLOTS  30
`define INDEX_W     5

// per-kind quantity inputs
`define QTY_W       5

// item word position fields
`define LEFT_W      13
`define TOP_W       12

// grid geometry, pixels per cell and largest cell coordinate
`define CELL_PITCH  16
`define GRID_MAX    20

// move delta, sign bit on top of the magnitude
`define DELTA_W     11

// linear congruential generator
`define RAND_W      9
`define RAND_SEED   173
`define RAND_MUL    43
`define RAND_ADD    181

`endif

//--- common/itemMapPkg.sv
// item map package: item kinds and the two decodes of the 32-bit item word
`include "itemMap_settings.svh"

package itemMapPkg;

    // kind codes as stored in the item word
    typedef enum logic [1:0] {
        itemStone   = 2'd0,
        itemGold    = 2'd1,
        itemDiamond = 2'd2
    } itemKind_e;

    // field view, used for placement output and move updates
    typedef struct packed {
        // pixel column
        logic [`LEFT_W-1:0] left;
        // pixel row
        logic [`TOP_W-1:0]  top;
        // reserved, kept as written
        logic [2:0]         spare;
        itemKind_e          kind;
        logic               visible;
        logic               moved;
    } itemFields_t;

    // key view, left and top together as one compare key
    typedef struct packed {
        logic [`LEFT_W+`TOP_W-1:0] posKey;
        // spare, kind, visible and moved
        logic [6:0]                attr;
    } itemKey_t;

    // one stored item word, decoded either way
    typedef union packed {
        itemFields_t fields;
        itemKey_t    key;
    } itemWord_u;

endpackage

//--- logic/randomSource.sv
// random source: 9-bit linear congruential generator stepping on every clock
`timescale 1ns/1ps
`include "itemMap_settings.svh"

module randomSource (
    input  logic               clock,
    input  logic               generateEn,
    output logic [`RAND_W-1:0] randValue
);

    localparam int unsigned RandW = `RAND_W;

    logic [RandW-1:0] nextValue;

    // value * a + c, wrapped to the generator width
    assign nextValue = RandW'(`RAND_MUL * randValue + `RAND_ADD);

    // seed held in reset, free running after that
    always_ff @(posedge clock or negedge generateEn) begin
        if (!generateEn) begin
            randValue <= RandW'(`RAND_SEED);
        end else begin
            randValue <= nextValue;
        end
    end

endmodule

//--- placement/placementControl.sv
// placement controller: draws random cells, rejects collisions and saves typed items
`timescale 1ns/1ps
`include "itemMap_settings.svh"

module placementControl
    import itemMapPkg::*;
(
    input  logic                clock,
    input  logic                generateEn,
    input  logic [`QTY_W-1:0]   stoneCount,
    input  logic [`QTY_W-1:0]   goldCount,
    input  logic [`QTY_W-1:0]   diamondCount,
    input  logic [`RAND_W-1:0]  randValue,
    output logic [`INDEX_W-1:0] scanIndex,
    input  itemWord_u           scanItem,
    output logic                saveEn,
    output logic [`INDEX_W-1:0] saveIndex,
    output itemWord_u           saveItem,
    output logic [`INDEX_W-1:0] itemCount,
    output logic                ready
);

    localparam int unsigned IndexW  = `INDEX_W;
    localparam int unsigned QtySumW = `QTY_W + 2;
    localparam int unsigned LeftW   = `LEFT_W;
    localparam int unsigned TopW    = `TOP_W;
    // random value split, y in the low bits
    localparam int unsigned RowBits = 4;
    localparam int unsigned ColBits = `RAND_W - RowBits;

    typedef enum logic [2:0] {
        stIdleCheck,
        stDraw,
        stScan,
        stSave,
        stDone
    } placeState_e;

    placeState_e        state;
    logic [QtySumW-1:0] qtySum;
    logic [QtySumW-1:0] goldLimit;
    logic [QtySumW-1:0] countWide;
    logic [IndexW-1:0]  targetCount;
    logic [IndexW-1:0]  nextCount;
    logic [IndexW-1:0]  lastIndex;
    logic [ColBits-1:0] cellX;
    logic [RowBits-1:0] cellY;
    logic [ColBits-1:0] colCell;
    logic [RowBits-1:0] rowCell;
    itemWord_u          candWord;
    itemWord_u          candItem;
    itemKind_e          saveKind;
    logic               keyHit;

    // target is the quantity sum, capped at the slot count
    assign qtySum      = QtySumW'(stoneCount) + QtySumW'(goldCount) + QtySumW'(diamondCount);
    assign targetCount = (qtySum > QtySumW'(`ITEM_SLOTS)) ? IndexW'(`ITEM_SLOTS)
                                                           : IndexW'(qtySum);

    assign nextCount = itemCount + IndexW'(1);
    assign lastIndex = itemCount - IndexW'(1);

    // fold x and y back into the grid
    assign cellX   = randValue[`RAND_W-1:RowBits];
    assign cellY   = randValue[RowBits-1:0];
    assign colCell = (cellX >= `GRID_MAX) ? ColBits'(2 * `GRID_MAX - cellX)
                                          : ColBits'(`GRID_MAX - cellX);
    assign rowCell = (cellY >= `GRID_MAX / 2) ? RowBits'(`GRID_MAX - cellY)
                                              : RowBits'(`GRID_MAX / 2 - cellY);

    // candidate word, kind filled in at save
    always_comb begin
        candWord                = '0;
        candWord.fields.left    = LeftW'(colCell * `CELL_PITCH);
        candWord.fields.top     = TopW'(rowCell * `CELL_PITCH);
        candWord.fields.visible = 1'b1;
        candWord.fields.moved   = 1'b0;
    end

    // only the position key takes part in the compare
    assign keyHit = (scanItem.key.posKey == candItem.key.posKey);

    // quantity-ordered typing: stones first, then gold, then diamonds
    assign goldLimit = QtySumW'(stoneCount) + QtySumW'(goldCount);
    assign countWide = QtySumW'(itemCount);
    always_comb begin
        if (countWide < QtySumW'(stoneCount)) begin
            saveKind = itemStone;
        end else if (countWide < goldLimit) begin
            saveKind = itemGold;
        end else begin
            saveKind = itemDiamond;
        end
    end

    // sampled once per draw, held through the scan
    always_ff @(posedge clock) begin
        if (state == stDraw) begin
            candItem <= candWord;
        end
    end

    always_ff @(posedge clock or negedge generateEn) begin
        if (!generateEn) begin
            state     <= stIdleCheck;
            scanIndex <= '0;
            itemCount <= '0;
        end else begin
            case (state)
                // empty target skips straight to done
                stIdleCheck: begin
                    if (itemCount >= targetCount) begin
                        state <= stDone;
                    end else begin
                        state <= stDraw;
                    end
                end
                stDraw: begin
                    scanIndex <= '0;
                    // nothing stored yet, no scan needed
                    if (itemCount == '0) begin
                        state <= stSave;
                    end else begin
                        state <= stScan;
                    end
                end
                // one stored item per cycle
                stScan: begin
                    if (keyHit) begin
                        // collision, redraw
                        state <= stDraw;
                    end else if (scanIndex == lastIndex) begin
                        state <= stSave;
                    end else begin
                        scanIndex <= scanIndex + IndexW'(1);
                    end
                end
                stSave: begin
                    itemCount <= nextCount;
                    if (nextCount >= targetCount) begin
                        state <= stDone;
                    end else begin
                        state <= stDraw;
                    end
                end
                // held until the next reset
                stDone: begin
                    state <= stDone;
                end
                default: begin
                    state <= stIdleCheck;
                end
            endcase
        end
    end

    // single-cycle save strobe into the next free slot
    assign saveEn    = (state == stSave);
    assign saveIndex = itemCount;
    always_comb begin
        saveItem             = candItem;
        saveItem.fields.kind = saveKind;
    end

    assign ready = (state == stDone);

endmodule

//--- logic/itemStore.sv
// item store: item word array with placement save, move update and two read ports
`timescale 1ns/1ps
`include "itemMap_settings.svh"

module itemStore
    import itemMapPkg::*;
(
    input  logic                clock,
    input  logic                generateEn,
    input  logic                ready,
    input  logic [`INDEX_W-1:0] itemCount,
    input  logic                saveEn,
    input  logic [`INDEX_W-1:0] saveIndex,
    input  itemWord_u           saveItem,
    input  logic [`INDEX_W-1:0] scanIndex,
    output itemWord_u           scanItem,
    input  logic                moveEn,
    input  logic [`INDEX_W-1:0] moveIndex,
    input  logic [`DELTA_W-1:0] moveDx,
    input  logic [`DELTA_W-1:0] moveDy,
    input  logic                moveState,
    input  logic                visible,
    input  logic [`INDEX_W-1:0] readIndex,
    output itemWord_u           readItem
);

    localparam int unsigned IndexW = `INDEX_W;
    localparam int unsigned Slots  = `ITEM_SLOTS;
    localparam int unsigned LeftW  = `LEFT_W;
    localparam int unsigned TopW   = `TOP_W;
    // magnitude bits below the sign
    localparam int unsigned MagW   = `DELTA_W - 1;
    localparam logic [IndexW-1:0] SlotLimit = IndexW'(`ITEM_SLOTS);

    itemWord_u        items [Slots];
    logic             moveAccept;
    itemWord_u        moveOld;
    itemWord_u        moveNew;
    logic [LeftW-1:0] stepX;
    logic [TopW-1:0]  stepY;

    // moves only after placement and only onto placed items
    assign moveAccept = moveEn && ready && (moveIndex < itemCount);

    assign moveOld = (moveIndex < SlotLimit) ? items[moveIndex] : '0;

    // magnitudes widened to the field widths
    assign stepX = LeftW'(moveDx[MagW-1:0]);
    assign stepY = TopW'(moveDy[MagW-1:0]);

    // sign-magnitude add, wraps inside each field
    always_comb begin
        moveNew = moveOld;
        if (moveDx[MagW]) begin
            moveNew.fields.left = moveOld.fields.left - stepX;
        end else begin
            moveNew.fields.left = moveOld.fields.left + stepX;
        end
        if (moveDy[MagW]) begin
            moveNew.fields.top = moveOld.fields.top - stepY;
        end else begin
            moveNew.fields.top = moveOld.fields.top + stepY;
        end
        // kind and spare bits pass through
        moveNew.fields.moved   = moveState;
        moveNew.fields.visible = visible;
    end

    // saves and moves never overlap, ready splits them
    always_ff @(posedge clock or negedge generateEn) begin
        if (!generateEn) begin
            for (int i = 0; i < Slots; i++) begin
                items[i] <= '0;
            end
        end else if (saveEn) begin
            items[saveIndex] <= saveItem;
        end else if (moveAccept) begin
            items[moveIndex] <= moveNew;
        end
    end

    // scan port for the collision check
    assign scanItem = (scanIndex < SlotLimit) ? items[scanIndex] : '0;

    // external read, zero past the last slot
    assign readItem = (readIndex < SlotLimit) ? items[readIndex] : '0;

endmodule

//--- logic/itemMap.sv
// item map top: random source, placement controller and item store
`timescale 1ns/1ps
`include "itemMap_settings.svh"

module itemMap
    import itemMapPkg::*;
(
    input  logic                clock,
    input  logic                generateEn,
    input  logic [`QTY_W-1:0]   stoneCount,
    input  logic [`QTY_W-1:0]   goldCount,
    input  logic [`QTY_W-1:0]   diamondCount,
    input  logic                moveEn,
    input  logic [`INDEX_W-1:0] moveIndex,
    input  logic [`DELTA_W-1:0] moveDx,
    input  logic [`DELTA_W-1:0] moveDy,
    input  logic                moveState,
    input  logic                visible,
    input  logic [`INDEX_W-1:0] readIndex,
    output itemWord_u           readItem,
    output logic                ready,
    output logic [`INDEX_W-1:0] itemCount
);

    logic [`RAND_W-1:0]  randValue;
    logic [`INDEX_W-1:0] scanIndex;
    itemWord_u           scanItem;
    logic                saveEn;
    logic [`INDEX_W-1:0] saveIndex;
    itemWord_u           saveItem;

    // free-running draw source
    randomSource u_randomSource (
        .clock      (clock),
        .generateEn (generateEn),
        .randValue  (randValue)
    );

    // fills the map after reset, then raises ready
    placementControl u_placementControl (
        .clock        (clock),
        .generateEn   (generateEn),
        .stoneCount   (stoneCount),
        .goldCount    (goldCount),
        .diamondCount (diamondCount),
        .randValue    (randValue),
        .scanIndex    (scanIndex),
        .scanItem     (scanItem),
        .saveEn       (saveEn),
        .saveIndex    (saveIndex),
        .saveItem     (saveItem),
        .itemCount    (itemCount),
        .ready        (ready)
    );

    // item words, move gating lives here
    itemStore u_itemStore (
        .clock      (clock),
        .generateEn (generateEn),
        .ready      (ready),
        .itemCount  (itemCount),
        .saveEn     (saveEn),
        .saveIndex  (saveIndex),
        .saveItem   (saveItem),
        .scanIndex  (scanIndex),
        .scanItem   (scanItem),
        .moveEn     (moveEn),
        .moveIndex  (moveIndex),
        .moveDx     (moveDx),
        .moveDy     (moveDy),
        .moveState  (moveState),
        .visible    (visible),
        .readIndex  (readIndex),
        .readItem   (readItem)
    );

endmodule

//--- test/itemMap_chk.sv
// item map checker: concurrent assertions on ready and itemCount
`timescale 1ns/1ps
`include "itemMap_settings.svh"

module itemMapChk (
    input logic                clock,
    input logic                generateEn,
    input logic                ready,
    input logic [`INDEX_W-1:0] itemCount
);

    int failCount = 0;

    // map never complete while held in reset
    readyInReset: assert property (@(posedge clock) !generateEn |-> !ready)
        else begin
            failCount++;
            $error("ready high while generateEn low");
        end

    // no more items than slots
    countCap: assert property (@(posedge clock) itemCount <= `ITEM_SLOTS)
        else begin
            failCount++;
            $error("itemCount above slot count");
        end

    // ready and itemCount frozen until the next reset
    holdAfterReady: assert property (@(posedge clock) disable iff (!generateEn)
        ready |=> (ready && $stable(itemCount)))
        else begin
            failCount++;
            $error("ready or itemCount changed after ready");
        end

endmodule

bind itemMap itemMapChk u_itemMapChk (
    .clock      (clock),
    .generateEn (generateEn),
    .ready      (ready),
    .itemCount  (itemCount)
);

//--- test/itemMapMonitor.sv
// item map monitor: reference model of placed and moved items, compares DUT reads
`timescale 1ns/1ps
`include "itemMap_settings.svh"

module itemMapMonitor
    import itemMapPkg::*;
(
    input  logic                clock,
    input  logic                generateEn,
    input  logic [`QTY_W-1:0]   stoneCount,
    input  logic [`QTY_W-1:0]   goldCount,
    input  logic [`QTY_W-1:0]   diamondCount,
    input  logic                moveEn,
    input  logic [`INDEX_W-1:0] moveIndex,
    input  logic [`DELTA_W-1:0] moveDx,
    input  logic [`DELTA_W-1:0] moveDy,
    input  logic                moveState,
    input  logic                visible,
    input  logic [`INDEX_W-1:0] readIndex,
    input  itemWord_u           readItem,
    input  logic                ready,
    input  logic [`INDEX_W-1:0] itemCount,
    input  logic                captureEn,
    input  logic                compareEn,
    output int                  errorCount
);

    itemWord_u model [`ITEM_SLOTS];
    string     testName;
    int        testErrors;
    int        testsRun;
    int        testsFailed;
    int        qtySum;
    int        expCount;
    logic      readySeen;

    initial begin
        testName    = "startup";
        testErrors  = 0;
        testsRun    = 0;
        testsFailed = 0;
        errorCount  = 0;
        readySeen   = 1'b0;
    end

    // expected item count, sum capped at the slot count
    assign qtySum   = int'(stoneCount) + int'(goldCount) + int'(diamondCount);
    assign expCount = (qtySum > `ITEM_SLOTS) ? `ITEM_SLOTS : qtySum;

    // wrong value against an expected one
    task automatic report(string what, longint expected, longint actual);
        errorCount++;
        testErrors++;
        $display("Error %s: %s expected %0h actual %0h", testName, what, expected, actual);
    endtask

    // failure without a single expected value
    task automatic fault(string text);
        errorCount++;
        testErrors++;
        $display("Problem in %s: %s", testName, text);
    endtask

    task automatic startTest(string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic finishTest();
        testsRun++;
        if (testErrors == 0) begin
            $display("test %s: ok", testName);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", testName, testErrors);
        end
    endtask

    task automatic printSummary();
        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errorCount);
    endtask

    // stones first, then gold, then diamonds
    function automatic itemKind_e kindFor(int n);
        if (n < int'(stoneCount)) begin
            return itemStone;
        end
        if (n < int'(stoneCount) + int'(goldCount)) begin
            return itemGold;
        end
        return itemDiamond;
    endfunction

    // sign-magnitude step on each axis, wraps in the field
    function automatic itemWord_u movedItem(itemWord_u old);
        itemWord_u w;
        int        magX;
        int        magY;
        w    = old;
        magX = int'(moveDx[`DELTA_W-2:0]);
        magY = int'(moveDy[`DELTA_W-2:0]);
        w.fields.left    = moveDx[`DELTA_W-1] ? `LEFT_W'(old.fields.left - magX)
                                              : `LEFT_W'(old.fields.left + magX);
        w.fields.top     = moveDy[`DELTA_W-1] ? `TOP_W'(old.fields.top - magY)
                                              : `TOP_W'(old.fields.top + magY);
        w.fields.moved   = moveState;
        w.fields.visible = visible;
        return w;
    endfunction

    // placement rules on one freshly placed item, then into the model
    task automatic checkPlaced();
        itemFields_t f;
        int          idx;
        f   = readItem.fields;
        idx = int'(readIndex);
        if (f.left % `CELL_PITCH != 0 || f.left / `CELL_PITCH > `GRID_MAX) begin
            fault($sformatf("item %0d left %0d is off the grid", idx, f.left));
        end
        if (f.top % `CELL_PITCH != 0 || f.top / `CELL_PITCH > `GRID_MAX) begin
            fault($sformatf("item %0d top %0d is off the grid", idx, f.top));
        end
        if (f.kind !== kindFor(idx)) begin
            report($sformatf("kind of item %0d", idx), kindFor(idx), f.kind);
        end
        if (f.visible !== 1'b1) begin
            report($sformatf("visible of item %0d", idx), 1, f.visible);
        end
        if (f.moved !== 1'b0) begin
            report($sformatf("moved of item %0d", idx), 0, f.moved);
        end
        // sweep runs upward, so earlier slots are already captured
        for (int j = 0; j < idx; j++) begin
            if (model[j].key.posKey == readItem.key.posKey) begin
                fault($sformatf("items %0d and %0d share a cell", j, idx));
            end
        end
        model[idx] = readItem;
    endtask

    // outputs sampled mid-cycle, away from both edges
    always @(negedge clock) begin
        if (!generateEn) begin
            readySeen = 1'b0;
            // every slot is cleared in reset
            for (int k = 0; k < `ITEM_SLOTS; k++) begin
                model[k] = '0;
            end
            if (ready !== 1'b0) begin
                report("ready in reset", 0, ready);
            end
            if (itemCount !== '0) begin
                report("itemCount in reset", 0, itemCount);
            end
        end else if (ready === 1'b1 && !readySeen) begin
            readySeen = 1'b1;
            if (int'(itemCount) != expCount) begin
                report("itemCount at ready", expCount, itemCount);
            end
        end
        if (generateEn && captureEn) begin
            checkPlaced();
        end
        if (generateEn && compareEn && readItem !== model[readIndex]) begin
            report($sformatf("item %0d", readIndex), model[readIndex], readItem);
        end
    end

    // accepted moves, same edge the DUT samples them on
    always @(posedge clock) begin
        if (generateEn && readySeen && moveEn && int'(moveIndex) < expCount) begin
            model[moveIndex] = movedItem(model[moveIndex]);
        end
    end

endmodule

//--- test/itemMapTb.sv
// item map testbench: clock, reset, seeded random quantities, moves and read sweeps
`timescale 1ns/1ps
`include "itemMap_settings.svh"

module itemMapTb;
    import itemMapPkg::*;

    localparam int ReadyTimeout = 40000;
    localparam int MoveCount    = 40;

    logic                clock;
    logic                generateEn;
    logic [`QTY_W-1:0]   stoneCount;
    logic [`QTY_W-1:0]   goldCount;
    logic [`QTY_W-1:0]   diamondCount;
    logic                moveEn;
    logic [`INDEX_W-1:0] moveIndex;
    logic [`DELTA_W-1:0] moveDx;
    logic [`DELTA_W-1:0] moveDy;
    logic                moveState;
    logic                visible;
    logic [`INDEX_W-1:0] readIndex;
    itemWord_u           readItem;
    logic                ready;
    logic [`INDEX_W-1:0] itemCount;
    logic                captureEn;
    logic                compareEn;
    int                  errorCount;
    int                  targetCount;
    int                  assertFails;
    int unsigned         seedDummy;
    bit                  timedOut;

    itemMap u_itemMap (
        .clock(clock), .generateEn(generateEn), .stoneCount(stoneCount),
        .goldCount(goldCount), .diamondCount(diamondCount), .moveEn(moveEn),
        .moveIndex(moveIndex), .moveDx(moveDx), .moveDy(moveDy), .moveState(moveState),
        .visible(visible), .readIndex(readIndex), .readItem(readItem), .ready(ready),
        .itemCount(itemCount)
    );

    itemMapMonitor u_monitor (
        .clock(clock), .generateEn(generateEn), .stoneCount(stoneCount),
        .goldCount(goldCount), .diamondCount(diamondCount), .moveEn(moveEn),
        .moveIndex(moveIndex), .moveDx(moveDx), .moveDy(moveDy), .moveState(moveState),
        .visible(visible), .readIndex(readIndex), .readItem(readItem), .ready(ready),
        .itemCount(itemCount), .captureEn(captureEn), .compareEn(compareEn),
        .errorCount(errorCount)
    );

    // 20 ns period
    initial clock = 1'b0;
    always #10 clock = ~clock;

    // inputs change 2 ns past the rising edge
    task automatic nextCycle();
        @(posedge clock);
        #2;
    endtask

    task automatic waitReady();
        int cyc;
        for (cyc = 0; cyc < ReadyTimeout && ready !== 1'b1; cyc++) begin
            nextCycle();
        end
        if (ready !== 1'b1) begin
            timedOut = 1'b1;
            $display("timeout: ready did not rise within %0d cycles", ReadyTimeout);
        end
    endtask

    // capture walks the placed items, compare walks every slot
    task automatic sweep(bit capture);
        int span;
        span = capture ? targetCount : `ITEM_SLOTS;
        for (int i = 0; i < span; i++) begin
            readIndex = `INDEX_W'(i);
            captureEn = capture;
            compareEn = !capture;
            nextCycle();
        end
        captureEn = 1'b0;
        compareEn = 1'b0;
    endtask

    // one reset, placement and capture sweep
    task automatic runRound(int stones, int golds, int diamonds, string tag);
        int sum;
        u_monitor.startTest({"reset ", tag});
        generateEn   = 1'b0;
        stoneCount   = `QTY_W'(stones);
        goldCount    = `QTY_W'(golds);
        diamondCount = `QTY_W'(diamonds);
        sum          = stones + golds + diamonds;
        targetCount  = (sum > `ITEM_SLOTS) ? `ITEM_SLOTS : sum;
        repeat (10) nextCycle();
        generateEn = 1'b1;
        u_monitor.finishTest();
        u_monitor.startTest({"placement ", tag});
        waitReady();
        // lets the monitor see the rise of ready
        nextCycle();
        u_monitor.finishTest();
        if (!timedOut) begin
            u_monitor.startTest({"sweep ", tag});
            sweep(1'b1);
            u_monitor.finishTest();
        end
    endtask

    task automatic driveMove(int idx);
        moveEn    = 1'b1;
        moveIndex = `INDEX_W'(idx);
        moveDx    = `DELTA_W'($urandom);
        moveDy    = `DELTA_W'($urandom);
        moveState = 1'($urandom);
        visible   = 1'($urandom);
        readIndex = `INDEX_W'(idx);
        nextCycle();
        moveEn = 1'b0;
    endtask

    task automatic moveTests();
        u_monitor.startTest("moves");
        for (int n = 0; n < MoveCount && targetCount > 0; n++) begin
            driveMove($urandom % targetCount);
            // result visible from the cycle after the move
            compareEn = 1'b1;
            nextCycle();
            compareEn = 1'b0;
        end
        u_monitor.finishTest();
        u_monitor.startTest("move past count");
        driveMove(targetCount + $urandom % (32 - targetCount));
        sweep(1'b0);
        u_monitor.finishTest();
    endtask

    initial begin
        // reset falls a moment in, once every block is running
        generateEn   = 1'b1;
        stoneCount   = '0;
        goldCount    = '0;
        diamondCount = '0;
        moveEn       = 1'b0;
        moveIndex    = '0;
        moveDx       = '0;
        moveDy       = '0;
        moveState    = 1'b0;
        visible      = 1'b0;
        readIndex    = '0;
        captureEn    = 1'b0;
        compareEn    = 1'b0;
        timedOut     = 1'b0;
        targetCount  = 0;
        seedDummy    = $urandom(32'haef6);
        #2;
        runRound(1 + $urandom % 10, 1 + $urandom % 10, 1 + $urandom % 10, "1");
        if (!timedOut) begin
            moveTests();
        end
        if (!timedOut) begin
            runRound($urandom % 11, $urandom % 11, $urandom % 11, "2");
        end
        // sum always above the slot count here
        if (!timedOut) begin
            runRound(11 + $urandom % 21, 11 + $urandom % 21, 11 + $urandom % 21, "3");
        end
        assertFails = u_itemMap.u_itemMapChk.failCount;
        if (assertFails != 0) begin
            $display("%0d assertion failures on ready or itemCount", assertFails);
        end
        u_monitor.printSummary();
        if (!timedOut && errorCount == 0 && assertFails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+common
common/itemMapPkg.sv
logic/randomSource.sv
placement/placementControl.sv
logic/itemStore.sv
logic/itemMap.sv
test/itemMap_chk.sv
test/itemMapMonitor.sv
test/itemMapTb.sv
